// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= operand_collector_tb
FLIST     ?= operand_collector.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/bank_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bank_port_if import oc_pkg::*; ();

    logic      req_valid;
    row_id_t   req_row;
    cu_id_t    req_cu;
    logic      req_slot;   // 0 = first operand

    logic      rsp_valid;
    cu_id_t    rsp_cu;
    logic      rsp_slot;
    lane_vec_t rsp_data;

    modport requester (
        output req_valid, req_row, req_cu, req_slot
    );

    modport bank (
        input  req_valid, req_row, req_cu, req_slot,
        output rsp_valid, rsp_cu, rsp_slot, rsp_data
    );

    modport collector (
        input rsp_valid, rsp_cu, rsp_slot, rsp_data
    );

endinterface

`default_nettype wire

// ==== design/banked_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oc_consts.svh"

module banked_regfile import oc_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wb_valid,
    input  warp_id_t   wb_warp,
    input  reg_id_t    wb_reg,
    input  lane_vec_t  wb_data,
    input  lane_mask_t wb_mask,
    bank_port_if.bank  bank [`OC_NUM_BANKS]
);

    bank_row_t wb_map;

    assign wb_map = map_bank_row(wb_warp, wb_reg);

    for (genvar b = 0; b < `OC_NUM_BANKS; b++) begin : g_bank
        lane_vec_t mem [`OC_NUM_ROWS];
        logic      wr_en;

        assign wr_en = wb_valid & (wb_map.bank == bank_id_t'(b));

        always_ff @(posedge clk) begin
            if (wr_en) begin
                for (int l = 0; l < `OC_LANES; l++) begin
                    if (wb_mask[l]) mem[wb_map.row][l] <= wb_data[l]; // inactive lanes kept
                end
            end
            if (bank[b].req_valid) begin
                bank[b].rsp_data <= mem[bank[b].req_row];
                bank[b].rsp_cu   <= bank[b].req_cu;
                bank[b].rsp_slot <= bank[b].req_slot;
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                bank[b].rsp_valid <= 1'b0;
            end else begin
                bank[b].rsp_valid <= bank[b].req_valid;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/collector_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oc_consts.svh"

module collector_unit import oc_pkg::*; #(
    parameter cu_id_t CU_ID = '0
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           alloc_en,
    input  instr_info_t    alloc_info,
    input  logic           alloc_need1,
    input  logic           alloc_need2,
    bank_port_if.collector bank [`OC_NUM_BANKS],
    input  logic           grant,
    output logic           busy,
    output logic           ready,
    output instr_info_t    info,
    output lane_vec_t      op1,
    output lane_vec_t      op2
);

    logic [`OC_NUM_BANKS-1:0] hit1;
    logic [`OC_NUM_BANKS-1:0] hit2;
    lane_vec_t                rsp_data [`OC_NUM_BANKS];
    logic                     filled1;
    logic                     filled2;

    for (genvar b = 0; b < `OC_NUM_BANKS; b++) begin : g_rsp
        logic mine;

        assign mine        = bank[b].rsp_valid & (bank[b].rsp_cu == CU_ID);
        assign hit1[b]     = mine & ~bank[b].rsp_slot;
        assign hit2[b]     = mine & bank[b].rsp_slot;
        assign rsp_data[b] = bank[b].rsp_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            filled1 <= 1'b0;
            filled2 <= 1'b0;
        end else if (alloc_en) begin
            busy    <= 1'b1;
            filled1 <= ~alloc_need1; // unused source counts as filled
            filled2 <= ~alloc_need2;
        end else begin
            if (grant) busy <= 1'b0;
            if (|hit1) filled1 <= 1'b1;
            if (|hit2) filled2 <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            info <= alloc_info;
            op1  <= '0;
            op2  <= '0;
        end else begin
            for (int b = 0; b < `OC_NUM_BANKS; b++) begin
                if (hit1[b]) op1 <= rsp_data[b];
                if (hit2[b]) op2 <= rsp_data[b];
            end
        end
    end

    assign ready = busy & filled1 & filled2;

endmodule

`default_nettype wire

// ==== design/dispatch_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oc_consts.svh"

module dispatch_arbiter import oc_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`OC_NUM_CU-1:0] ready,
    input  instr_info_t           info [`OC_NUM_CU],
    input  lane_vec_t             op1 [`OC_NUM_CU],
    input  lane_vec_t             op2 [`OC_NUM_CU],
    output logic [`OC_NUM_CU-1:0] grant,
    output logic                  alu_valid,
    output logic                  mem_valid,
    output instr_info_t           alu_info,
    output instr_info_t           mem_info,
    output lane_vec_t             alu_op1,
    output lane_vec_t             alu_op2,
    output lane_vec_t             mem_op1,
    output lane_vec_t             mem_op2
);

    typedef struct packed {
        logic   hit;
        cu_id_t idx;
    } pick_t;

    // first requester at or after ptr
    function automatic pick_t rr_pick(input logic [`OC_NUM_CU-1:0] req, input cu_id_t ptr);
        pick_t  p;
        cu_id_t idx;
        p = '0;
        for (int i = `OC_NUM_CU - 1; i >= 0; i--) begin
            idx = ptr + cu_id_t'(i);
            if (req[idx]) begin
                p.hit = 1'b1;
                p.idx = idx;
            end
        end
        return p;
    endfunction

    logic [`OC_NUM_CU-1:0] alu_req;
    logic [`OC_NUM_CU-1:0] mem_req;
    cu_id_t                alu_ptr;
    cu_id_t                mem_ptr;
    pick_t                 alu_pick;
    pick_t                 mem_pick;

    always_comb begin
        for (int i = 0; i < `OC_NUM_CU; i++) begin
            alu_req[i] = ready[i] & ~info[i].is_mem;
            mem_req[i] = ready[i] & info[i].is_mem;
        end
    end

    assign alu_pick = rr_pick(alu_req, alu_ptr);
    assign mem_pick = rr_pick(mem_req, mem_ptr);

    always_comb begin
        grant = '0;
        if (alu_pick.hit) grant[alu_pick.idx] = 1'b1;
        if (mem_pick.hit) grant[mem_pick.idx] = 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_ptr   <= '0;
            mem_ptr   <= '0;
            alu_valid <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            alu_valid <= alu_pick.hit;
            mem_valid <= mem_pick.hit;
            if (alu_pick.hit) alu_ptr <= alu_pick.idx + 1'b1; // winner goes last
            if (mem_pick.hit) mem_ptr <= mem_pick.idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_pick.hit) begin
            alu_info <= info[alu_pick.idx];
            alu_op1  <= op1[alu_pick.idx];
            alu_op2  <= op2[alu_pick.idx];
        end
        if (mem_pick.hit) begin
            mem_info <= info[mem_pick.idx];
            mem_op1  <= op1[mem_pick.idx];
            mem_op2  <= op2[mem_pick.idx];
        end
    end

endmodule

`default_nettype wire

// ==== design/oc_consts.svh ====
`ifndef OC_CONSTS_SVH
`define OC_CONSTS_SVH

`define OC_NUM_BANKS      4
`define OC_BANK_W         2
`define OC_NUM_ROWS       16
`define OC_ROW_W          4
`define OC_NUM_CU         4
`define OC_CU_W           2
`define OC_NUM_WARPS      8
`define OC_WARP_W         3
`define OC_REGS_PER_WARP  8
`define OC_REG_W          3
`define OC_LANES          8
`define OC_LANE_WIDTH     32

// one entry per operand slot, so a queue never fills
`define OC_QUEUE_DEPTH    8
`define OC_QPTR_W         3

`endif

// ==== design/oc_pkg.sv ====
`default_nettype none
`include "oc_consts.svh"

package oc_pkg;

    typedef logic [`OC_WARP_W-1:0] warp_id_t;
    typedef logic [`OC_REG_W-1:0]  reg_id_t;
    typedef logic [`OC_BANK_W-1:0] bank_id_t;
    typedef logic [`OC_ROW_W-1:0]  row_id_t;
    typedef logic [`OC_CU_W-1:0]   cu_id_t;
    typedef logic [`OC_LANES-1:0]  lane_mask_t;
    typedef logic [`OC_LANES-1:0][`OC_LANE_WIDTH-1:0] lane_vec_t;

    typedef struct packed {
        reg_id_t    dst;
        logic [15:0] imme;
        logic       imme_valid;
        logic [3:0] alu_op;
        logic       is_mem;     // selects the memory output
        logic       mem_write;
        lane_mask_t mask;
    } instr_info_t;

    typedef struct packed {
        bank_id_t bank;
        row_id_t  row;
    } bank_row_t;

    // bank = (reg + warp) mod 4, row = 2*warp + reg/4
    function automatic bank_row_t map_bank_row(input warp_id_t warp, input reg_id_t rid);
        bank_row_t m;
        m.bank = bank_id_t'(rid + warp);
        m.row  = row_id_t'({warp, 1'b0}) + row_id_t'(rid >> 2);
        return m;
    endfunction

endpackage

`default_nettype wire

// ==== design/operand_collector.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oc_consts.svh"

module operand_collector import oc_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        issue_valid,
    input  warp_id_t    issue_warp,
    input  reg_id_t     issue_src1,
    input  logic        issue_src1_valid,
    input  reg_id_t     issue_src2,
    input  logic        issue_src2_valid,
    input  reg_id_t     issue_dst,
    input  logic [15:0] issue_imme,
    input  logic        issue_imme_valid,
    input  logic [3:0]  issue_alu_op,
    input  logic        issue_is_mem,
    input  logic        issue_mem_write,
    input  lane_mask_t  issue_mask,
    output logic        full,
    input  logic        wb_valid,
    input  warp_id_t    wb_warp,
    input  reg_id_t     wb_reg,
    input  lane_vec_t   wb_data,
    input  lane_mask_t  wb_mask,
    output logic        alu_valid,
    output reg_id_t     alu_dst,
    output logic [15:0] alu_imme,
    output logic        alu_imme_valid,
    output logic [3:0]  alu_op,
    output lane_mask_t  alu_mask,
    output lane_vec_t   alu_op1,
    output lane_vec_t   alu_op2,
    output logic        mem_valid,
    output reg_id_t     mem_dst,
    output logic [15:0] mem_imme,
    output logic        mem_write,
    output lane_mask_t  mem_mask,
    output lane_vec_t   mem_op1,
    output lane_vec_t   mem_op2
);

    instr_info_t           issue_info;
    instr_info_t           alloc_info;
    instr_info_t           alu_info;
    instr_info_t           mem_info;
    logic [`OC_NUM_CU-1:0] alloc_en;
    logic                  alloc_need1;
    logic                  alloc_need2;
    logic [`OC_NUM_CU-1:0] cu_busy;
    logic [`OC_NUM_CU-1:0] cu_ready;
    logic [`OC_NUM_CU-1:0] grant;
    instr_info_t           cu_info [`OC_NUM_CU];
    lane_vec_t             cu_op1 [`OC_NUM_CU];
    lane_vec_t             cu_op2 [`OC_NUM_CU];

    bank_port_if bank_if [`OC_NUM_BANKS] ();

    assign issue_info = '{
        dst:        issue_dst,
        imme:       issue_imme,
        imme_valid: issue_imme_valid,
        alu_op:     issue_alu_op,
        is_mem:     issue_is_mem,
        mem_write:  issue_mem_write,
        mask:       issue_mask
    };

    operand_request u_request (
        .clk, .arst_n,
        .issue_valid, .issue_warp, .issue_src1, .issue_src2,
        .issue_src1_valid, .issue_src2_valid, .issue_info,
        .cu_busy, .wb_valid, .wb_warp, .wb_reg,
        .full, .alloc_en, .alloc_info, .alloc_need1, .alloc_need2,
        .bank (bank_if)
    );

    banked_regfile u_regfile (
        .clk, .arst_n,
        .wb_valid, .wb_warp, .wb_reg, .wb_data, .wb_mask,
        .bank (bank_if)
    );

    for (genvar i = 0; i < `OC_NUM_CU; i++) begin : g_cu
        collector_unit #(.CU_ID(cu_id_t'(i))) u_cu (
            .clk, .arst_n,
            .alloc_en    (alloc_en[i]),
            .alloc_info, .alloc_need1, .alloc_need2,
            .bank        (bank_if),
            .grant       (grant[i]),
            .busy        (cu_busy[i]),
            .ready       (cu_ready[i]),
            .info        (cu_info[i]),
            .op1         (cu_op1[i]),
            .op2         (cu_op2[i])
        );
    end

    dispatch_arbiter u_dispatch (
        .clk, .arst_n,
        .ready (cu_ready),
        .info  (cu_info),
        .op1   (cu_op1),
        .op2   (cu_op2),
        .grant,
        .alu_valid, .mem_valid, .alu_info, .mem_info,
        .alu_op1, .alu_op2, .mem_op1, .mem_op2
    );

    assign alu_dst        = alu_info.dst;
    assign alu_imme       = alu_info.imme;
    assign alu_imme_valid = alu_info.imme_valid;
    assign alu_op         = alu_info.alu_op;
    assign alu_mask       = alu_info.mask;

    assign mem_dst   = mem_info.dst;
    assign mem_imme  = mem_info.imme;
    assign mem_write = mem_info.mem_write;
    assign mem_mask  = mem_info.mask;

endmodule

`default_nettype wire

// ==== design/operand_request.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oc_consts.svh"

module operand_request import oc_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue_valid,
    input  warp_id_t              issue_warp,
    input  reg_id_t               issue_src1,
    input  reg_id_t               issue_src2,
    input  logic                  issue_src1_valid,
    input  logic                  issue_src2_valid,
    input  instr_info_t           issue_info,
    input  logic [`OC_NUM_CU-1:0] cu_busy,
    input  logic                  wb_valid,
    input  warp_id_t              wb_warp,
    input  reg_id_t               wb_reg,
    output logic                  full,
    output logic [`OC_NUM_CU-1:0] alloc_en,
    output instr_info_t           alloc_info,
    output logic                  alloc_need1,
    output logic                  alloc_need2,
    bank_port_if.requester        bank [`OC_NUM_BANKS]
);

    typedef logic [`OC_QPTR_W-1:0] qptr_t;
    typedef logic [`OC_QPTR_W:0]   qcnt_t;

    typedef struct packed {
        row_id_t row;
        cu_id_t  cu;
        logic    slot;
    } req_t;

    cu_id_t    free_cu;
    logic      accept;
    bank_row_t src1_map;
    bank_row_t src2_map;
    bank_row_t wb_map;

    always_comb begin
        free_cu = '0;
        for (int i = `OC_NUM_CU - 1; i >= 0; i--) begin
            if (!cu_busy[i]) free_cu = cu_id_t'(i); // lowest free wins
        end
    end

    assign full   = &cu_busy;
    assign accept = issue_valid & ~full;

    assign src1_map = map_bank_row(issue_warp, issue_src1);
    assign src2_map = map_bank_row(issue_warp, issue_src2);
    assign wb_map   = map_bank_row(wb_warp, wb_reg);

    always_comb begin
        alloc_en = '0;
        if (accept) alloc_en[free_cu] = 1'b1;
    end

    assign alloc_info  = issue_info;
    assign alloc_need1 = issue_src1_valid;
    assign alloc_need2 = issue_src2_valid;

    for (genvar b = 0; b < `OC_NUM_BANKS; b++) begin : g_queue
        req_t  q [`OC_QUEUE_DEPTH];
        qptr_t wr_ptr;
        qptr_t rd_ptr;
        qcnt_t count;
        logic  push1;
        logic  push2;
        logic  pop;

        assign push1 = accept & issue_src1_valid & (src1_map.bank == bank_id_t'(b));
        assign push2 = accept & issue_src2_valid & (src2_map.bank == bank_id_t'(b));
        // write-back owns the bank this cycle
        assign pop   = (count != '0) & ~(wb_valid & (wb_map.bank == bank_id_t'(b)));

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                wr_ptr <= wr_ptr + qptr_t'(push1) + qptr_t'(push2);
                rd_ptr <= rd_ptr + qptr_t'(pop);
                count  <= count + qcnt_t'(push1) + qcnt_t'(push2) - qcnt_t'(pop);
            end
        end

        always_ff @(posedge clk) begin
            if (push1) q[wr_ptr] <= {src1_map.row, free_cu, 1'b0};
            if (push2) q[wr_ptr + qptr_t'(push1)] <= {src2_map.row, free_cu, 1'b1};
        end

        assign bank[b].req_valid = pop;
        assign bank[b].req_row   = q[rd_ptr].row;
        assign bank[b].req_cu    = q[rd_ptr].cu;
        assign bank[b].req_slot  = q[rd_ptr].slot;
    end

endmodule

`default_nettype wire

// ==== dv/operand_collector_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oc_consts.svh"

module operand_collector_tb import oc_pkg::*; ();

    localparam int MAX_CYCLES = 3000; // tests take about 350 cycles
    localparam int NUM_TAGS   = 256;

    logic        clk;
    logic        arst_n;
    logic        issue_valid;
    warp_id_t    issue_warp;
    reg_id_t     issue_src1;
    logic        issue_src1_valid;
    reg_id_t     issue_src2;
    logic        issue_src2_valid;
    reg_id_t     issue_dst;
    logic [15:0] issue_imme;
    logic        issue_imme_valid;
    logic [3:0]  issue_alu_op;
    logic        issue_is_mem;
    logic        issue_mem_write;
    lane_mask_t  issue_mask;
    logic        full;
    logic        wb_valid;
    warp_id_t    wb_warp;
    reg_id_t     wb_reg;
    lane_vec_t   wb_data;
    lane_mask_t  wb_mask;
    logic        alu_valid;
    reg_id_t     alu_dst;
    logic [15:0] alu_imme;
    logic        alu_imme_valid;
    logic [3:0]  alu_op;
    lane_mask_t  alu_mask;
    lane_vec_t   alu_op1;
    lane_vec_t   alu_op2;
    logic        mem_valid;
    reg_id_t     mem_dst;
    logic [15:0] mem_imme;
    logic        mem_write;
    lane_mask_t  mem_mask;
    lane_vec_t   mem_op1;
    lane_vec_t   mem_op2;

    logic [31:0] lfsr;
    lane_vec_t   ref_rf [`OC_NUM_WARPS][`OC_REGS_PER_WARP];
    instr_info_t exp_info [NUM_TAGS];
    lane_vec_t   exp_op1 [NUM_TAGS];
    lane_vec_t   exp_op2 [NUM_TAGS];
    logic        live [NUM_TAGS];  // issued, not yet seen on an output
    int          next_tag;
    int          issued_count;
    int          done_count;
    int          checks;
    int          errors;
    int          cycles;

    operand_collector u_operand_collector (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles with outputs outstanding", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic lane_vec_t rand_vec();
        lane_vec_t v;
        for (int l = 0; l < `OC_LANES; l++) v[l] = rand_bits(32);
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] exp_v,
                                   input logic [255:0] got_v);
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
        errors++;
    endtask

    task automatic check_alu();
        int          t;
        instr_info_t e;
        t = int'(alu_imme);
        if (t >= NUM_TAGS || !live[t] || exp_info[t].is_mem) begin
            $display("ALU output at %0t carries tag %0d of no pending ALU instruction",
                     $time, t);
            errors++;
        end else begin
            e = exp_info[t];
            checks++;
            if (alu_dst !== e.dst) report_mismatch("alu_dst", 256'(e.dst), 256'(alu_dst));
            if (alu_op !== e.alu_op) report_mismatch("alu_op", 256'(e.alu_op), 256'(alu_op));
            if (alu_mask !== e.mask) report_mismatch("alu_mask", 256'(e.mask), 256'(alu_mask));
            if (alu_imme_valid !== e.imme_valid)
                report_mismatch("alu_imme_valid", 256'(e.imme_valid), 256'(alu_imme_valid));
            if (alu_op1 !== exp_op1[t]) report_mismatch("alu_op1", exp_op1[t], alu_op1);
            if (alu_op2 !== exp_op2[t]) report_mismatch("alu_op2", exp_op2[t], alu_op2);
            live[t] = 1'b0;
            done_count++;
        end
    endtask

    task automatic check_mem();
        int          t;
        instr_info_t e;
        t = int'(mem_imme);
        if (t >= NUM_TAGS || !live[t] || !exp_info[t].is_mem) begin
            $display("memory output at %0t carries tag %0d of no pending memory instruction",
                     $time, t);
            errors++;
        end else begin
            e = exp_info[t];
            checks++;
            if (mem_dst !== e.dst) report_mismatch("mem_dst", 256'(e.dst), 256'(mem_dst));
            if (mem_mask !== e.mask) report_mismatch("mem_mask", 256'(e.mask), 256'(mem_mask));
            if (mem_write !== e.mem_write)
                report_mismatch("mem_write", 256'(e.mem_write), 256'(mem_write));
            if (mem_op1 !== exp_op1[t]) report_mismatch("mem_op1", exp_op1[t], mem_op1);
            if (mem_op2 !== exp_op2[t]) report_mismatch("mem_op2", exp_op2[t], mem_op2);
            live[t] = 1'b0;
            done_count++;
        end
    endtask

    // outputs are registered, so the edge sees last cycle's values
    always @(posedge clk) begin
        if (alu_valid === 1'b1) check_alu();
        if (mem_valid === 1'b1) check_mem();
    end

    task automatic write_reg(input warp_id_t w, input reg_id_t r, input lane_vec_t d,
                             input lane_mask_t m);
        for (int l = 0; l < `OC_LANES; l++) begin
            if (m[l]) ref_rf[w][r][l] = d[l];
        end
        wb_valid = 1'b1;
        wb_warp  = w;
        wb_reg   = r;
        wb_data  = d;
        wb_mask  = m;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic issue(input warp_id_t w, input reg_id_t s1, input logic v1,
                         input reg_id_t s2, input logic v2, input logic mem, input logic iv);
        instr_info_t e;
        int          t;
        t            = next_tag;
        next_tag++;
        e.dst        = reg_id_t'(rand_bits(3));
        e.imme       = 16'(t); // imme doubles as the match tag
        e.imme_valid = iv;
        e.alu_op     = 4'(rand_bits(4));
        e.is_mem     = mem;
        e.mem_write  = mem & 1'(rand_bits(1));
        e.mask       = lane_mask_t'(rand_bits(8));
        exp_info[t]  = e;
        exp_op1[t]   = v1 ? ref_rf[w][s1] : '0;
        exp_op2[t]   = v2 ? ref_rf[w][s2] : '0;
        live[t]      = 1'b1;
        issued_count++;
        issue_valid      = 1'b1;
        issue_warp       = w;
        issue_src1       = s1;
        issue_src1_valid = v1;
        issue_src2       = s2;
        issue_src2_valid = v2;
        issue_dst        = e.dst;
        issue_imme       = e.imme;
        issue_imme_valid = e.imme_valid;
        issue_alu_op     = e.alu_op;
        issue_is_mem     = e.is_mem;
        issue_mem_write  = e.mem_write;
        issue_mask       = e.mask;
        while (full) @(negedge clk); // held until a collector frees
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_done();
        while (done_count != issued_count) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int err_start);
        if (errors == err_start) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - err_start);
    endtask

    task automatic basic_alu_read();
        int e0;
        e0 = errors;
        write_reg(3'd5, 3'd1, rand_vec(), 8'hff);
        write_reg(3'd5, 3'd2, rand_vec(), 8'hff);
        issue(3'd5, 3'd1, 1'b1, 3'd2, 1'b1, 1'b0, 1'b0);
        wait_done();
        issue(3'd7, 3'd6, 1'b1, 3'd0, 1'b1, 1'b0, 1'b0);
        wait_done();
        end_test("basic ALU read", e0);
    endtask

    task automatic masked_write_back();
        int e0;
        e0 = errors;
        write_reg(3'd6, 3'd3, rand_vec(), 8'h5a);
        write_reg(3'd4, 3'd7, rand_vec(), 8'h81);
        issue(3'd6, 3'd3, 1'b1, 3'd2, 1'b1, 1'b0, 1'b0);
        issue(3'd4, 3'd7, 1'b1, 3'd3, 1'b1, 1'b1, 1'b0);
        wait_done();
        end_test("masked write-back", e0);
    endtask

    task automatic immediate_form();
        int e0;
        e0 = errors;
        issue(3'd2, 3'd4, 1'b1, 3'd0, 1'b0, 1'b0, 1'b1);
        issue(3'd3, 3'd6, 1'b1, 3'd1, 1'b0, 1'b1, 1'b1);
        wait_done();
        end_test("immediate form", e0);
    endtask

    task automatic bank_conflict_mix();
        int       e0;
        warp_id_t w;
        reg_id_t  a;
        reg_id_t  b;
        logic     m;
        e0 = errors;
        // every source here maps to bank 1
        issue(3'd0, 3'd1, 1'b1, 3'd5, 1'b1, 1'b0, 1'b0);
        issue(3'd1, 3'd0, 1'b1, 3'd4, 1'b1, 1'b0, 1'b0);
        issue(3'd2, 3'd7, 1'b1, 3'd3, 1'b1, 1'b1, 1'b0);
        issue(3'd5, 3'd4, 1'b1, 3'd0, 1'b1, 1'b0, 1'b0);
        wait_done();
        for (int i = 0; i < 12; i++) begin
            w = warp_id_t'(rand_bits(3));
            a = reg_id_t'(rand_bits(3));
            b = reg_id_t'(rand_bits(3));
            m = 1'(rand_bits(1));
            issue(w, a, 1'b1, b, 1'b1, m, 1'b0);
        end
        wait_done();
        end_test("bank conflicts and mapping", e0);
    endtask

    task automatic full_backpressure();
        int        e0;
        int        done0;
        int        low_cycles;
        lane_vec_t d;
        e0         = errors;
        low_cycles = 0;
        d          = rand_vec();
        ref_rf[0][0] = d;
        wb_valid = 1'b1; // bank 0 owned by write-back
        wb_warp  = 3'd0;
        wb_reg   = 3'd0;
        wb_data  = d;
        wb_mask  = 8'hff;
        issue(3'd0, 3'd4, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0);
        issue(3'd1, 3'd3, 1'b1, 3'd7, 1'b1, 1'b1, 1'b0);
        issue(3'd2, 3'd2, 1'b1, 3'd6, 1'b1, 1'b0, 1'b0);
        issue(3'd3, 3'd1, 1'b1, 3'd5, 1'b1, 1'b1, 1'b0);
        done0 = done_count;
        for (int i = 0; i < 10; i++) begin
            if (full !== 1'b1) low_cycles++;
            @(negedge clk);
        end
        if (low_cycles != 0) begin
            $display("full was low for %0d cycles while bank 0 was held", low_cycles);
            errors++;
        end
        if (done_count != done0) begin
            $display("an instruction dispatched while its bank was held by write-back");
            errors++;
        end
        wb_valid = 1'b0;
        wait_done();
        if (full !== 1'b0) report_mismatch("full", 256'(1'b0), 256'(full));
        end_test("full", e0);
    endtask

    initial begin
        arst_n           = 1'b0;
        issue_valid      = 1'b0;
        issue_warp       = '0;
        issue_src1       = '0;
        issue_src1_valid = 1'b0;
        issue_src2       = '0;
        issue_src2_valid = 1'b0;
        issue_dst        = '0;
        issue_imme       = '0;
        issue_imme_valid = 1'b0;
        issue_alu_op     = '0;
        issue_is_mem     = 1'b0;
        issue_mem_write  = 1'b0;
        issue_mask       = '0;
        wb_valid         = 1'b0;
        wb_warp          = '0;
        wb_reg           = '0;
        wb_data          = '0;
        wb_mask          = '0;
        lfsr             = 32'haba84a82;
        next_tag         = 0;
        issued_count     = 0;
        done_count       = 0;
        checks           = 0;
        errors           = 0;
        cycles           = 0;
        for (int i = 0; i < NUM_TAGS; i++) live[i] = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        // storage has no reset
        for (int w = 0; w < `OC_NUM_WARPS; w++) begin
            for (int r = 0; r < `OC_REGS_PER_WARP; r++) begin
                write_reg(warp_id_t'(w), reg_id_t'(r), rand_vec(), 8'hff);
            end
        end
        basic_alu_read();
        masked_write_back();
        immediate_form();
        bank_conflict_mix();
        full_backpressure();
        repeat (10) @(negedge clk); // catch stray or repeated outputs
        $display("outputs checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== operand_collector.f ====
+incdir+design
design/oc_pkg.sv
design/bank_port_if.sv
design/operand_request.sv
design/banked_regfile.sv
design/collector_unit.sv
design/dispatch_arbiter.sv
design/operand_collector.sv
dv/operand_collector_tb.sv
